// File: hdl/cpu_pkg.sv
// ----------------------------
// Shared types and encodings for the byte CPU
// Field positions follow the six-ROM instruction layout
// ----------------------------
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;    // Data byte on buses, regs, RAM
    typedef logic [15:0] addr_t;    // PC and data address bus
    typedef logic [47:0] instr_t;   // ROM6..ROM1 concatenated
    typedef logic [4:0]  alu_op_t;
    typedef logic [2:0]  dev_t;     // A or B source
    typedef logic [3:0]  tdev_t;    // Target device
    typedef logic [3:0]  cond_t;
    typedef logic [7:0]  flags_t;   // Bit 0 carry up to bit 7 ne

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HALTED
    } run_state_t;

    // ----------------------------
    // Instruction field positions
    // ----------------------------
    localparam int IMMED_LSB  = 0;   // ROM1
    localparam int DADDR_LSB  = 8;   // ROM2 lo byte, ROM3 hi byte
    localparam int AMODE_BIT  = 24;  // High selects direct address
    localparam int INVERT_BIT = 27;  // Positive logic
    localparam int SETF_N_BIT = 28;  // Active low
    localparam int COND_LSB   = 29;  // Straddles ROM4 and ROM5
    localparam int BDEV_LSB   = 33;
    localparam int ADEV_LSB   = 36;
    localparam int TDEV_LSB   = 39;  // Straddles ROM5 and ROM6
    localparam int ALUOP_LSB  = 43;

    // Flag bit positions
    localparam int FLAG_C  = 0;
    localparam int FLAG_Z  = 1;
    localparam int FLAG_O  = 2;
    localparam int FLAG_N  = 3;
    localparam int FLAG_GT = 4;
    localparam int FLAG_LT = 5;
    localparam int FLAG_EQ = 6;
    localparam int FLAG_NE = 7;

    // ----------------------------
    // ALU operations
    // ----------------------------
    localparam alu_op_t ALU_ZERO   = 5'd0;
    localparam alu_op_t ALU_PASS_A = 5'd1;
    localparam alu_op_t ALU_PASS_B = 5'd2;
    localparam alu_op_t ALU_ADD    = 5'd3;
    localparam alu_op_t ALU_SUB_AB = 5'd4;   // A - B
    localparam alu_op_t ALU_SUB_BA = 5'd5;   // B - A
    localparam alu_op_t ALU_AND    = 5'd6;
    localparam alu_op_t ALU_OR     = 5'd7;
    localparam alu_op_t ALU_XOR    = 5'd8;
    localparam alu_op_t ALU_INC_A  = 5'd9;
    localparam alu_op_t ALU_DEC_A  = 5'd10;

    // A bus sources, 5 to 7 read as zero
    localparam dev_t ADEV_REGA  = 3'd0;
    localparam dev_t ADEV_REGB  = 3'd1;
    localparam dev_t ADEV_MARLO = 3'd2;
    localparam dev_t ADEV_MARHI = 3'd3;
    localparam dev_t ADEV_IN    = 3'd4;

    // B bus sources, 6 and 7 read as zero
    localparam dev_t BDEV_REGA  = 3'd0;
    localparam dev_t BDEV_REGB  = 3'd1;
    localparam dev_t BDEV_MARLO = 3'd2;
    localparam dev_t BDEV_MARHI = 3'd3;
    localparam dev_t BDEV_IMMED = 3'd4;
    localparam dev_t BDEV_RAM   = 3'd5;

    // Targets, 9 to 15 write nothing
    localparam tdev_t TDEV_REGA    = 4'd0;
    localparam tdev_t TDEV_REGB    = 4'd1;
    localparam tdev_t TDEV_MARLO   = 4'd2;
    localparam tdev_t TDEV_MARHI   = 4'd3;
    localparam tdev_t TDEV_OUT     = 4'd4;
    localparam tdev_t TDEV_RAM     = 4'd5;
    localparam tdev_t TDEV_HALT    = 4'd6;
    localparam tdev_t TDEV_PCHITMP = 4'd7;
    localparam tdev_t TDEV_PC      = 4'd8;

    // ----------------------------
    // Condition select, 11 to 15 always true
    // ----------------------------
    localparam cond_t COND_ALWAYS = 4'd0;
    localparam cond_t COND_CARRY  = 4'd1;
    localparam cond_t COND_ZERO   = 4'd2;
    localparam cond_t COND_OVF    = 4'd3;
    localparam cond_t COND_NEG    = 4'd4;
    localparam cond_t COND_GT     = 4'd5;
    localparam cond_t COND_LT     = 4'd6;
    localparam cond_t COND_EQ     = 4'd7;
    localparam cond_t COND_NE     = 4'd8;
    localparam cond_t COND_DI     = 4'd9;   // Input byte waiting
    localparam cond_t COND_DO     = 4'd10;  // Output can accept

endpackage

`default_nettype wire

// File: hdl/program_rom.sv
// ----------------------------
// Program store, written only while the CPU is idle
// Read is combinational and wraps past the depth
// ----------------------------
`default_nettype none

module program_rom #(
    parameter int PROG_AWIDTH = 8
) (
    input  logic                   clk,
    input  logic                   we,      // Already qualified by idle
    input  logic [PROG_AWIDTH-1:0] waddr,
    input  cpu_pkg::instr_t        wdata,
    input  cpu_pkg::addr_t         raddr,
    output cpu_pkg::instr_t        instr
);
    import cpu_pkg::*;

    instr_t mem [2**PROG_AWIDTH];

    // Load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign instr = mem[raddr[PROG_AWIDTH-1:0]];  // Low PC bits only

endmodule

`default_nettype wire

// File: hdl/controller.sv
// ----------------------------
// Instruction decode and conditional execution
// All device selects are one-hot and active low
// ----------------------------
`default_nettype none

module controller (
    input  cpu_pkg::instr_t  instr,
    input  cpu_pkg::flags_t  flags,         // Latched by earlier instructions
    input  logic             di,
    input  logic             do_rdy,
    output cpu_pkg::alu_op_t alu_op,
    output cpu_pkg::byte_t   immed,
    output cpu_pkg::addr_t   direct_addr,
    output logic             addrmode_reg_n,
    output logic [7:0]       adev_sel_n,
    output logic [7:0]       bdev_sel_n,
    output logic [15:0]      tdev_sel_n,
    output logic             set_flags_n
);
    import cpu_pkg::*;

    cond_t       cond;
    logic        cond_invert;
    logic        set_flags_bit_n;
    dev_t        adev;
    dev_t        bdev;
    tdev_t       tdev;
    logic [15:0] cond_vec;      // One entry per condition index
    logic        cond_met;
    logic        exec;

    // ----------------------------
    // Field split
    // ----------------------------
    assign immed           = instr[IMMED_LSB +: $bits(byte_t)];
    assign direct_addr     = instr[DADDR_LSB +: $bits(addr_t)];
    assign addrmode_reg_n  = instr[AMODE_BIT];     // Low means MAR addressing
    assign cond_invert     = instr[INVERT_BIT];
    assign set_flags_bit_n = instr[SETF_N_BIT];
    assign cond            = instr[COND_LSB +: $bits(cond_t)];
    assign bdev            = instr[BDEV_LSB +: $bits(dev_t)];
    assign adev            = instr[ADEV_LSB +: $bits(dev_t)];
    assign tdev            = instr[TDEV_LSB +: $bits(tdev_t)];
    assign alu_op          = instr[ALUOP_LSB +: $bits(alu_op_t)];

    // ----------------------------
    // 16-way condition mux
    // ----------------------------
    always_comb begin
        cond_vec              = '1;              // Spare indices act as always
        cond_vec[COND_ALWAYS] = 1'b1;
        cond_vec[COND_CARRY]  = flags[FLAG_C];
        cond_vec[COND_ZERO]   = flags[FLAG_Z];
        cond_vec[COND_OVF]    = flags[FLAG_O];
        cond_vec[COND_NEG]    = flags[FLAG_N];
        cond_vec[COND_GT]     = flags[FLAG_GT];
        cond_vec[COND_LT]     = flags[FLAG_LT];
        cond_vec[COND_EQ]     = flags[FLAG_EQ];
        cond_vec[COND_NE]     = flags[FLAG_NE];
        cond_vec[COND_DI]     = di;
        cond_vec[COND_DO]     = do_rdy;
    end

    assign cond_met = cond_vec[cond];
    assign exec     = cond_met ^ cond_invert;    // Invert turns DO into not DO

    // Flags update only on an executed instruction that asks for it
    assign set_flags_n = ~(exec & ~set_flags_bit_n);

    // Source decoders run regardless of exec
    assign adev_sel_n = ~(8'd1 << adev);
    assign bdev_sel_n = ~(8'd1 << bdev);

    // Target decoder held off when the condition fails
    assign tdev_sel_n = exec ? ~(16'd1 << tdev) : '1;

endmodule

`default_nettype wire

// File: hdl/alu.sv
// ----------------------------
// Byte ALU, purely combinational
// Inc and dec set carry as add or subtract of one
// ----------------------------
`default_nettype none

module alu (
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::byte_t   result,
    output cpu_pkg::flags_t  flags
);
    import cpu_pkg::*;

    logic [8:0] wide;   // Bit 8 is carry out or borrow
    logic       ovf;

    always_comb begin
        wide = 9'd0;
        ovf  = 1'b0;
        case (op)
            ALU_PASS_A: wide = {1'b0, a};
            ALU_PASS_B: wide = {1'b0, b};
            ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                ovf  = (a[7] == b[7]) && (wide[7] != a[7]);
            end
            ALU_SUB_AB: begin
                wide = {1'b0, a} - {1'b0, b};
                ovf  = (a[7] != b[7]) && (wide[7] != a[7]);
            end
            ALU_SUB_BA: begin
                wide = {1'b0, b} - {1'b0, a};
                ovf  = (a[7] != b[7]) && (wide[7] != b[7]);
            end
            ALU_AND:    wide = {1'b0, a & b};
            ALU_OR:     wide = {1'b0, a | b};
            ALU_XOR:    wide = {1'b0, a ^ b};
            ALU_INC_A: begin
                wide = {1'b0, a} + 9'd1;
                ovf  = (a == 8'h7f);           // Max positive wraps
            end
            ALU_DEC_A: begin
                wide = {1'b0, a} - 9'd1;
                ovf  = (a == 8'h80);           // Min negative wraps
            end
            default:    wide = 9'd0;           // ALU_ZERO and unused codes
        endcase
    end

    assign result = wide[7:0];

    // Flag assembly
    always_comb begin
        flags          = '0;
        flags[FLAG_C]  = wide[8];              // Zero for logic ops
        flags[FLAG_Z]  = (wide[7:0] == 8'd0);
        flags[FLAG_O]  = ovf;
        flags[FLAG_N]  = wide[7];
        flags[FLAG_GT] = (a > b);              // Unsigned compares of A with B
        flags[FLAG_LT] = (a < b);
        flags[FLAG_EQ] = (a == b);
        flags[FLAG_NE] = (a != b);
    end

endmodule

`default_nettype wire

// File: hdl/datapath.sv
// ----------------------------
// Registers, flags, data RAM and byte ports
// Nothing is written unless run_en is high
// ----------------------------
`default_nettype none

module datapath #(
    parameter int RAM_AWIDTH = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             run_en,
    input  logic [7:0]       adev_sel_n,
    input  logic [7:0]       bdev_sel_n,
    input  logic [15:0]      tdev_sel_n,     // Already gated by exec
    input  cpu_pkg::byte_t   immed,
    input  cpu_pkg::addr_t   direct_addr,
    input  logic             addrmode_reg_n,
    input  logic             set_flags_n,
    input  cpu_pkg::byte_t   alu_result,
    input  cpu_pkg::flags_t  alu_flags,
    output cpu_pkg::byte_t   a_bus,
    output cpu_pkg::byte_t   b_bus,
    output cpu_pkg::flags_t  flags,
    input  cpu_pkg::byte_t   in_data,
    output logic             in_ack,
    output cpu_pkg::byte_t   out_data,
    output logic             out_valid
);
    import cpu_pkg::*;

    byte_t rega;
    byte_t regb;
    byte_t marlo;
    byte_t marhi;
    byte_t ram [2**RAM_AWIDTH];
    addr_t data_addr;

    // Direct when the mode bit is high, else through the MAR
    assign data_addr = addrmode_reg_n ? direct_addr : {marhi, marlo};

    // ----------------------------
    // Bus source muxes
    // ----------------------------
    always_comb begin
        a_bus = '0;                                           // Unused selects read zero
        if (!adev_sel_n[ADEV_REGA])  a_bus = rega;
        if (!adev_sel_n[ADEV_REGB])  a_bus = regb;
        if (!adev_sel_n[ADEV_MARLO]) a_bus = marlo;
        if (!adev_sel_n[ADEV_MARHI]) a_bus = marhi;
        if (!adev_sel_n[ADEV_IN])    a_bus = in_data;
    end

    always_comb begin
        b_bus = '0;
        if (!bdev_sel_n[BDEV_REGA])  b_bus = rega;
        if (!bdev_sel_n[BDEV_REGB])  b_bus = regb;
        if (!bdev_sel_n[BDEV_MARLO]) b_bus = marlo;
        if (!bdev_sel_n[BDEV_MARHI]) b_bus = marhi;
        if (!bdev_sel_n[BDEV_IMMED]) b_bus = immed;
        if (!bdev_sel_n[BDEV_RAM])   b_bus = ram[data_addr[RAM_AWIDTH-1:0]];
    end

    // Some target is selected exactly when the instruction executes
    assign in_ack = run_en & ~adev_sel_n[ADEV_IN] & ~&tdev_sel_n;

    // ----------------------------
    // Register and flag writes
    // ----------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rega      <= '0;
            regb      <= '0;
            marlo     <= '0;
            marhi     <= '0;
            flags     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;                                // Single cycle strobe
            if (run_en) begin
                if (!tdev_sel_n[TDEV_REGA])  rega  <= alu_result;
                if (!tdev_sel_n[TDEV_REGB])  regb  <= alu_result;
                if (!tdev_sel_n[TDEV_MARLO]) marlo <= alu_result;
                if (!tdev_sel_n[TDEV_MARHI]) marhi <= alu_result;
                if (!tdev_sel_n[TDEV_OUT])   out_valid <= 1'b1;
                if (!set_flags_n)            flags <= alu_flags;
            end
        end
    end

    // RAM and output byte
    always_ff @(posedge clk) begin
        if (run_en && !tdev_sel_n[TDEV_OUT]) begin
            out_data <= alu_result;                           // Held until next write
        end
        if (run_en && !tdev_sel_n[TDEV_RAM]) begin
            ram[data_addr[RAM_AWIDTH-1:0]] <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/program_counter.sv
// ----------------------------
// 16-bit PC with two-step jump
// Jump target is pchitmp as high byte and the ALU result as low
// ----------------------------
`default_nettype none

module program_counter (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           run_en,
    input  logic           pchitmp_sel_n,
    input  logic           pc_sel_n,
    input  cpu_pkg::byte_t value,
    output cpu_pkg::addr_t pc
);
    import cpu_pkg::*;

    byte_t pchitmp;   // Staged high byte

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pchitmp <= '0;
            pc      <= '0;
        end else if (run_en) begin
            if (!pchitmp_sel_n) pchitmp <= value;
            if (!pc_sel_n) begin
                pc <= {pchitmp, value};    // Jump
            end else begin
                pc <= pc + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/run_control.sv
// ----------------------------
// Idle, run and halted sequencing
// Halted is left only through reset
// ----------------------------
`default_nettype none

module run_control (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    input  logic halt_sel_n,   // Halt target, already gated by exec
    output logic run_en,
    output logic halted,
    output logic load_en
);
    import cpu_pkg::*;

    run_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) state <= ST_RUN;
                end
                ST_RUN: begin
                    if (!halt_sel_n) state <= ST_HALTED;   // Same edge as the write
                end
                default: state <= ST_HALTED;
            endcase
        end
    end

    assign load_en = (state == ST_IDLE);    // Program port open
    assign run_en  = (state == ST_RUN);
    assign halted  = (state == ST_HALTED);

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
// ----------------------------
// Byte CPU top level
// Load the program while idle, then pulse start
// ----------------------------
`default_nettype none

module cpu_top #(
    parameter int PROG_AWIDTH = 8,
    parameter int RAM_AWIDTH  = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   prog_we,
    input  logic [PROG_AWIDTH-1:0] prog_addr,
    input  cpu_pkg::instr_t        prog_data,
    input  logic                   start,
    output logic                   halted,
    input  cpu_pkg::byte_t         in_data,
    input  logic                   in_valid,    // DI flag
    output logic                   in_ack,
    output cpu_pkg::byte_t         out_data,
    output logic                   out_valid,
    input  logic                   out_ready    // DO flag
);
    import cpu_pkg::*;

    instr_t      instr;
    flags_t      flags;
    alu_op_t     alu_op;
    byte_t       immed;
    addr_t       direct_addr;
    logic        addrmode_reg_n;
    logic [7:0]  adev_sel_n;
    logic [7:0]  bdev_sel_n;
    logic [15:0] tdev_sel_n;
    logic        set_flags_n;
    byte_t       a_bus;
    byte_t       b_bus;
    byte_t       alu_result;
    flags_t      alu_flags;
    addr_t       pc;
    logic        run_en;
    logic        load_en;

    program_rom #(.PROG_AWIDTH(PROG_AWIDTH)) u_rom (
        .clk(clk), .we(prog_we & load_en), .waddr(prog_addr), .wdata(prog_data),
        .raddr(pc), .instr(instr)
    );

    controller u_ctrl (
        .instr(instr), .flags(flags), .di(in_valid), .do_rdy(out_ready),
        .alu_op(alu_op), .immed(immed), .direct_addr(direct_addr),
        .addrmode_reg_n(addrmode_reg_n), .adev_sel_n(adev_sel_n),
        .bdev_sel_n(bdev_sel_n), .tdev_sel_n(tdev_sel_n), .set_flags_n(set_flags_n)
    );

    alu u_alu (
        .a(a_bus), .b(b_bus), .op(alu_op), .result(alu_result), .flags(alu_flags)
    );

    datapath #(.RAM_AWIDTH(RAM_AWIDTH)) u_dp (
        .clk(clk), .arst_n(arst_n), .run_en(run_en),
        .adev_sel_n(adev_sel_n), .bdev_sel_n(bdev_sel_n), .tdev_sel_n(tdev_sel_n),
        .immed(immed), .direct_addr(direct_addr), .addrmode_reg_n(addrmode_reg_n),
        .set_flags_n(set_flags_n), .alu_result(alu_result), .alu_flags(alu_flags),
        .a_bus(a_bus), .b_bus(b_bus), .flags(flags),
        .in_data(in_data), .in_ack(in_ack), .out_data(out_data), .out_valid(out_valid)
    );

    // Jump low byte comes from the ALU result
    program_counter u_pc (
        .clk(clk), .arst_n(arst_n), .run_en(run_en),
        .pchitmp_sel_n(tdev_sel_n[TDEV_PCHITMP]), .pc_sel_n(tdev_sel_n[TDEV_PC]),
        .value(alu_result), .pc(pc)
    );

    run_control u_run (
        .clk(clk), .arst_n(arst_n), .start(start), .halt_sel_n(tdev_sel_n[TDEV_HALT]),
        .run_en(run_en), .halted(halted), .load_en(load_en)
    );

endmodule

`default_nettype wire

// File: test/cpu_tb_prog.svh
// ------------------------------
// Test programs, input bytes and expected output bytes
// Unused program words hold halt
// ------------------------------
`ifndef CPU_TB_PROG_SVH
`define CPU_TB_PROG_SVH

task automatic fill_cases();
    for (int c = 0; c < NCASE; c++) begin
        for (int i = 0; i < 16; i++) prog_tab[c][i] = halt_word();
        n_in_tab[c]  = 0;
        n_exp_tab[c] = 0;
    end

    // Immediates straight to the output port
    prog_tab[0][0] = to_imm(TDEV_OUT, 8'h5a);
    prog_tab[0][1] = to_imm(TDEV_OUT, 8'hc3);
    prog_tab[0][2] = to_imm(TDEV_OUT, 8'h01);
    exp_tab[0][0:2] = '{8'h5a, 8'hc3, 8'h01};
    n_exp_tab[0] = 3;

    // Arithmetic on two input bytes, 200 and 100
    prog_tab[1][0]  = to_imm(TDEV_PCHITMP, 8'h00);
    prog_tab[1][1]  = jump_if_not(COND_DI, 8'd0);
    prog_tab[1][2]  = op_word(ALU_PASS_A, TDEV_REGA, ADEV_IN, BDEV_NONE, COND_ALWAYS, 1'b1);
    prog_tab[1][3]  = jump_if_not(COND_DI, 8'd3);
    prog_tab[1][4]  = op_word(ALU_PASS_A, TDEV_REGB, ADEV_IN, BDEV_NONE, COND_ALWAYS, 1'b1);
    prog_tab[1][5]  = op_word(ALU_ADD, TDEV_OUT, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b0);
    prog_tab[1][6]  = op_word(ALU_SUB_AB, TDEV_OUT, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b1);
    prog_tab[1][7]  = op_word(ALU_SUB_BA, TDEV_OUT, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b1);
    prog_tab[1][8]  = op_word(ALU_AND, TDEV_OUT, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b1);
    prog_tab[1][9]  = op_word(ALU_XOR, TDEV_OUT, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b1);
    prog_tab[1][10] = word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_IMMED, COND_CARRY,
                           1'b0, 1'b1, 1'b0, 16'h0000, 8'h01);   // Carry from the add
    in_tab[1][0:1]  = '{8'hc8, 8'h64};
    n_in_tab[1]     = 2;
    exp_tab[1][0:5] = '{8'h2c, 8'h64, 8'h9c, 8'h40, 8'hac, 8'h01};
    n_exp_tab[1]    = 6;

    // Wait loops on DI and DO, output each byte plus one
    for (int blk = 0; blk < 2; blk++) begin
        prog_tab[2][blk*6]   = to_imm(TDEV_PCHITMP, 8'h00);
        prog_tab[2][blk*6+1] = jump_if_not(COND_DI, 8'(blk*6));
        prog_tab[2][blk*6+2] = op_word(ALU_PASS_A, TDEV_REGA, ADEV_IN, BDEV_NONE,
                                       COND_ALWAYS, 1'b1);
        prog_tab[2][blk*6+3] = to_imm(TDEV_PCHITMP, 8'h00);
        prog_tab[2][blk*6+4] = jump_if_not(COND_DO, 8'(blk*6+3));
        prog_tab[2][blk*6+5] = op_word(ALU_INC_A, TDEV_OUT, ADEV_REGA, BDEV_NONE,
                                       COND_ALWAYS, 1'b1);
    end
    in_tab[2][0:1]  = '{8'h10, 8'hff};
    n_in_tab[2]     = 2;
    exp_tab[2][0:1] = '{8'h11, 8'h00};
    n_exp_tab[2]    = 2;

    // RAM by direct address and through the MAR
    prog_tab[3][0] = word(ALU_PASS_B, TDEV_RAM, ADEV_NONE, BDEV_IMMED, COND_ALWAYS,
                          1'b0, 1'b1, 1'b1, 16'h0040, 8'h77);
    prog_tab[3][1] = to_imm(TDEV_MARLO, 8'h41);
    prog_tab[3][2] = to_imm(TDEV_MARHI, 8'h00);
    prog_tab[3][3] = to_imm(TDEV_RAM, 8'h99);                  // MAR mode
    prog_tab[3][4] = word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_RAM, COND_ALWAYS,
                          1'b0, 1'b1, 1'b1, 16'h0041, 8'h00);
    prog_tab[3][5] = to_imm(TDEV_MARLO, 8'h40);
    prog_tab[3][6] = op_word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_RAM, COND_ALWAYS, 1'b1);
    exp_tab[3][0:1] = '{8'h99, 8'h77};
    n_exp_tab[3]    = 2;

    // Flags held by an inactive set-flags bit or a failed condition
    prog_tab[4][0]  = to_imm(TDEV_REGA, 8'h05);
    prog_tab[4][1]  = to_imm(TDEV_REGB, 8'h05);
    prog_tab[4][2]  = op_word(ALU_SUB_AB, TDEV_NONE, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b0);
    prog_tab[4][3]  = to_imm(TDEV_REGB, 8'h07);
    prog_tab[4][4]  = op_word(ALU_SUB_AB, TDEV_NONE, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b1);
    prog_tab[4][5]  = word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_IMMED, COND_EQ,
                           1'b0, 1'b1, 1'b0, 16'h0000, 8'he1);
    prog_tab[4][6]  = op_word(ALU_SUB_AB, TDEV_NONE, ADEV_REGA, BDEV_REGB, COND_NE, 1'b0);
    prog_tab[4][7]  = word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_IMMED, COND_EQ,
                           1'b0, 1'b1, 1'b0, 16'h0000, 8'he2);
    prog_tab[4][8]  = word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_IMMED, COND_NE,
                           1'b0, 1'b1, 1'b0, 16'h0000, 8'hbb);
    prog_tab[4][9]  = op_word(ALU_SUB_AB, TDEV_NONE, ADEV_REGA, BDEV_REGB, COND_ALWAYS, 1'b0);
    prog_tab[4][10] = word(ALU_PASS_B, TDEV_OUT, ADEV_NONE, BDEV_IMMED, COND_NE,
                           1'b0, 1'b1, 1'b0, 16'h0000, 8'he3);
    exp_tab[4][0:2] = '{8'he1, 8'he2, 8'he3};
    n_exp_tab[4]    = 3;

    // Word 3 gets a halt written during the run, which must not land
    for (int i = 0; i < 4; i++) begin
        prog_tab[5][i] = to_imm(TDEV_OUT, 8'(8'h11 * (i + 1)));
    end
    exp_tab[5][0:3] = '{8'h11, 8'h22, 8'h33, 8'h44};
    n_exp_tab[5]    = 4;
endtask

`endif

// File: test/cpu_tb.sv
// ------------------------------
// Testbench for cpu_top, runs every table case in turn
// Stalls on both byte ports come from a fixed-seed LFSR
// ------------------------------
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam int NCASE       = 6;
    localparam int CASE_CYCLES = 400;                    // Worst run with stalls
    localparam int SETUP       = 3 + 16 + 2;             // Reset, load, start
    localparam int TIMEOUT     = NCASE * (CASE_CYCLES + SETUP);
    localparam dev_t  ADEV_NONE = 3'd5;                  // Reads zero
    localparam dev_t  BDEV_NONE = 3'd6;
    localparam tdev_t TDEV_NONE = 4'd9;                  // Writes nothing

    logic       clk;
    logic       arst_n;
    logic       prog_we;
    logic [7:0] prog_addr;
    instr_t     prog_data;
    logic       start;
    logic       halted;
    byte_t      in_data;
    logic       in_valid;
    logic       in_ack;
    byte_t      out_data;
    logic       out_valid;
    logic       out_ready;

    // Case table
    instr_t prog_tab [NCASE][16];
    byte_t  in_tab [NCASE][8];
    int     n_in_tab [NCASE];
    byte_t  exp_tab [NCASE][8];
    int     n_exp_tab [NCASE];

    logic [15:0] lfsr_state = 16'd18150;
    int          cycle_count = 0;
    int          n_got;
    int          in_idx;
    logic        in_taken;                               // Byte consumed last cycle
    logic        done;

    cpu_top dut (
        .clk(clk), .arst_n(arst_n), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .start(start), .halted(halted), .in_data(in_data),
        .in_valid(in_valid), .in_ack(in_ack), .out_data(out_data),
        .out_valid(out_valid), .out_ready(out_ready)
    );

    // ------------------------------
    // Instruction encoding
    // ------------------------------
    function automatic instr_t word(alu_op_t op, tdev_t t, dev_t a, dev_t b, cond_t c,
                                    logic inv, logic setf_n, logic amode, addr_t daddr,
                                    byte_t imm);
        instr_t w;
        w = '0;
        w[ALUOP_LSB +: 5]  = op;
        w[TDEV_LSB +: 4]   = t;
        w[ADEV_LSB +: 3]   = a;
        w[BDEV_LSB +: 3]   = b;
        w[COND_LSB +: 4]   = c;
        w[INVERT_BIT]      = inv;
        w[SETF_N_BIT]      = setf_n;
        w[AMODE_BIT]       = amode;
        w[DADDR_LSB +: 16] = daddr;
        w[IMMED_LSB +: 8]  = imm;
        return w;
    endfunction

    function automatic instr_t op_word(alu_op_t op, tdev_t t, dev_t a, dev_t b, cond_t c,
                                       logic setf_n);
        return word(op, t, a, b, c, 1'b0, setf_n, 1'b0, 16'h0000, 8'h00);
    endfunction

    function automatic instr_t to_imm(tdev_t t, byte_t v);
        return word(ALU_PASS_B, t, ADEV_NONE, BDEV_IMMED, COND_ALWAYS,
                    1'b0, 1'b1, 1'b0, 16'h0000, v);
    endfunction

    // Second jump step, taken while the condition is false
    function automatic instr_t jump_if_not(cond_t c, byte_t target);
        return word(ALU_PASS_B, TDEV_PC, ADEV_NONE, BDEV_IMMED, c,
                    1'b1, 1'b1, 1'b0, 16'h0000, target);
    endfunction

    function automatic instr_t halt_word();
        return op_word(ALU_ZERO, TDEV_HALT, ADEV_NONE, BDEV_NONE, COND_ALWAYS, 1'b1);
    endfunction

    `include "cpu_tb_prog.svh"

    // Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic next_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT)
            else report_failure("timeout, the CPU never halted");
    end

    task automatic apply_reset();
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 8'h00;
        prog_data = '0;
        start     = 1'b0;
        in_data   = 8'h00;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        assert (!halted && !out_valid && !in_ack)
            else report_failure("outputs not idle after reset");
    endtask

    task automatic load_program(int c);
        for (int i = 0; i < 16; i++) begin
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = prog_tab[c][i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
    endtask

    // Drive one cycle of port stimulus, 1 ns after the edge
    task automatic drive_ports(int c, logic clobber);
        logic b1;
        logic b2;
        prog_we   = clobber;                             // Must be ignored in run
        prog_addr = 8'd3;
        prog_data = halt_word();
        if (in_taken) begin
            in_idx++;
            in_taken = 1'b0;
            in_valid = 1'b0;
        end
        if (!in_valid && in_idx < n_in_tab[c]) begin
            next_bit(b1);
            in_valid = b1;                               // Held once raised
        end
        in_data = (in_idx < n_in_tab[c]) ? in_tab[c][in_idx] : 8'h00;
        next_bit(b1);
        next_bit(b2);
        out_ready = ~(b1 & b2);                          // Low one cycle in four
    endtask

    // Sample at the falling edge where outputs are settled
    task automatic sample_ports(int c, output logic fin);
        if (in_ack) begin
            assert (in_valid) else report_failure("input read while in_valid was low");
            in_taken = 1'b1;
        end
        if (out_valid) begin
            assert (n_got < n_exp_tab[c])
                else report_failure($sformatf("case %0d wrote too many output bytes", c));
            assert (out_data == exp_tab[c][n_got])
                else report_failure($sformatf("error t=%0t out_data got %h expected %h",
                                              $time, out_data, exp_tab[c][n_got]));
            n_got++;
        end
        fin = halted;
    endtask

    initial begin
        fill_cases();
        for (int c = 0; c < NCASE; c++) begin
            apply_reset();
            load_program(c);
            start = 1'b1;
            @(posedge clk);
            #1;
            start    = 1'b0;
            n_got    = 0;
            in_idx   = 0;
            in_taken = 1'b0;
            done     = 1'b0;
            for (int k = 0; !done; k++) begin
                drive_ports(c, k == 0);
                @(negedge clk);
                sample_ports(c, done);
                @(posedge clk);                          // Next case starts after an edge too
                #1;
            end
            assert (n_got == n_exp_tab[c])
                else report_failure($sformatf("case %0d halted after %0d of %0d bytes",
                                              c, n_got, n_exp_tab[c]));
            assert (in_idx + int'(in_taken) == n_in_tab[c])
                else report_failure($sformatf("case %0d left input bytes unread", c));
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_top.f
+incdir+test
hdl/cpu_pkg.sv
hdl/program_rom.sv
hdl/controller.sv
hdl/alu.sv
hdl/datapath.sv
hdl/program_counter.sv
hdl/run_control.sv
hdl/cpu_top.sv
test/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f cpu_top.f -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0
